/* verilog/fifo_pkg.sv */
package fifo_pkg;

    // ------------------------------------------------------------------------
    // Buffer sizing
    // ------------------------------------------------------------------------

    // Default number of entries in the sample FIFO
    localparam int DEFAULT_DEPTH = 8;

    // Count width for an FWFT FIFO
    // Must hold DEPTH plus one for the word sitting in the output register
    function automatic int cnt_wid(input int depth);
        int wid;
        wid = $clog2(depth + 2);
        return wid;
    endfunction

endpackage : fifo_pkg

/* verilog/stream_pkg.sv */
package stream_pkg;

    // ------------------------------------------------------------------------
    // Stream payload
    // ------------------------------------------------------------------------

    // Raw sample value
    typedef logic [15:0] sample_data_t;

    // Frame number, wraps after 255
    typedef logic [7:0] frame_id_t;

    // Word stored in the FIFO
    typedef struct packed {
        sample_data_t data;
        frame_id_t    frame;
        logic         last;
    } sample_t;

    // Per-frame sum, modulo 2**24
    typedef logic [23:0] frame_sum_t;

endpackage : stream_pkg

/* verilog/fifo_ram_sdp.sv */
`timescale 1ns/1ps

module fifo_ram_sdp #(
    parameter type DATA_T = logic [15:0],
    parameter int DEPTH = fifo_pkg::DEFAULT_DEPTH,
    localparam int ADDR_WID = $clog2(DEPTH)
) (
    input  logic                rd_clk,
    input  logic                wr_en,
    input  logic [ADDR_WID-1:0] wr_addr,
    input  DATA_T               wr_data,
    input  logic                rd_en,
    input  logic [ADDR_WID-1:0] rd_addr,
    output DATA_T               rd_data
);

    // Storage array
    DATA_T mem [DEPTH];

    // Write port
    always_ff @(posedge rd_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read port
    // rd_data holds its value between reads, the FWFT output relies on this
    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule : fifo_ram_sdp

/* verilog/fifo_core.sv */
`timescale 1ns/1ps

module fifo_core #(
    parameter type DATA_T = logic [15:0],
    parameter int DEPTH = fifo_pkg::DEFAULT_DEPTH
) (
    input  logic                                 rd_clk,
    input  logic                                 local_rd_srst,
    input  logic                                 wr,
    input  DATA_T                                wr_data,
    output logic                                 wr_full,
    output logic                                 wr_oflow,
    input  logic                                 rd,
    output DATA_T                                rd_data,
    output logic                                 rd_empty,
    output logic [fifo_pkg::cnt_wid(DEPTH)-1:0]  rd_count,
    output logic                                 rd_uflow
);

    import fifo_pkg::*;

    localparam int PTR_WID = $clog2(DEPTH);
    localparam int CNT_WID = cnt_wid(DEPTH);

    logic               wr_safe;
    logic               mem_rd;
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    // Words held in the RAM, not counting the prefetched one
    logic [CNT_WID-1:0] mem_count;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    fifo_ram_sdp #(
        .DATA_T ( DATA_T ),
        .DEPTH  ( DEPTH )
    ) fifo_ram_sdp_inst (
        .rd_clk  ( rd_clk ),
        .wr_en   ( wr_safe ),
        .wr_addr ( wr_ptr ),
        .wr_data ( wr_data ),
        .rd_en   ( mem_rd ),
        .rd_addr ( rd_ptr ),
        .rd_data ( rd_data )
    );

    // ------------------------------------------------------------------------
    // Pointer and count control
    // ------------------------------------------------------------------------
    assign wr_full  = (rd_count >= CNT_WID'(DEPTH));
    assign wr_safe  = wr && !wr_full;
    assign wr_oflow = wr && wr_full;

    // Prefetch whenever the output register is free or being popped
    assign mem_rd = (mem_count != '0) && (rd_empty || rd);

    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            wr_ptr <= '0;
        end else if (wr_safe) begin
            wr_ptr <= (wr_ptr == PTR_WID'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            rd_ptr <= '0;
        end else if (mem_rd) begin
            rd_ptr <= (rd_ptr == PTR_WID'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            mem_count <= '0;
        end else begin
            case ({wr_safe, mem_rd})
                2'b10:   mem_count <= mem_count + 1'b1;
                2'b01:   mem_count <= mem_count - 1'b1;
                default: mem_count <= mem_count;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // FWFT output state
    // ------------------------------------------------------------------------
    // Empty tracks the output register, not the RAM
    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            rd_empty <= 1'b1;
        end else if (mem_rd) begin
            rd_empty <= 1'b0;
        end else if (rd) begin
            rd_empty <= 1'b1;
        end
    end

    assign rd_count = mem_count + CNT_WID'(!rd_empty);
    assign rd_uflow = rd && rd_empty;

    // Credits upstream and the empty check downstream keep these quiet
    a_no_oflow: assert property (@(posedge rd_clk) disable iff (local_rd_srst) !wr_oflow)
        else $error("fifo_core: write while full");
    a_no_uflow: assert property (@(posedge rd_clk) disable iff (local_rd_srst) !rd_uflow)
        else $error("fifo_core: read while empty");
    a_count_max: assert property (@(posedge rd_clk) disable iff (local_rd_srst)
        rd_count <= CNT_WID'(DEPTH))
        else $error("fifo_core: count above depth");

endmodule : fifo_core

/* verilog/sample_producer.sv */
`timescale 1ns/1ps

module sample_producer #(
    parameter int DEPTH = fifo_pkg::DEFAULT_DEPTH
) (
    input  logic                     rd_clk,
    input  logic                     local_rd_srst,
    input  logic                     in_valid,
    input  stream_pkg::sample_data_t in_data,
    input  logic                     in_last,
    output logic                     in_ready,
    input  logic                     credit_return,
    output logic                     wr,
    output stream_pkg::sample_t      wr_data
);

    import fifo_pkg::*;
    import stream_pkg::*;

    localparam int CNT_WID = cnt_wid(DEPTH);

    logic [CNT_WID-1:0] credits;
    frame_id_t          frame_num;
    logic               accept;

    assign in_ready = (credits != '0);
    assign accept   = in_valid && in_ready;

    // ------------------------------------------------------------------------
    // Credit counter
    // ------------------------------------------------------------------------
    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            credits <= CNT_WID'(DEPTH);
        end else begin
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Frame number advances after the last sample of a frame
    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            frame_num <= '0;
        end else if (accept && in_last) begin
            frame_num <= frame_num + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Registered FIFO write
    // ------------------------------------------------------------------------
    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            wr <= 1'b0;
        end else begin
            wr <= accept;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (accept) begin
            wr_data.data  <= in_data;
            wr_data.frame <= frame_num;
            wr_data.last  <= in_last;
        end
    end

    // Consumer returns one credit per pop only
    a_credit_max: assert property (@(posedge rd_clk) disable iff (local_rd_srst)
        credits <= CNT_WID'(DEPTH))
        else $error("sample_producer: credits above depth");

endmodule : sample_producer

/* verilog/sample_consumer.sv */
`timescale 1ns/1ps

module sample_consumer (
    input  logic                     rd_clk,
    input  logic                     local_rd_srst,
    input  logic                     rd_empty,
    input  stream_pkg::sample_t      rd_data,
    output logic                     rd,
    output logic                     credit_return,
    output logic                     out_valid,
    input  logic                     out_ready,
    output stream_pkg::sample_data_t out_data,
    output stream_pkg::frame_id_t    out_frame,
    output logic                     out_last,
    output logic                     frame_valid,
    output stream_pkg::frame_sum_t   frame_sum,
    output stream_pkg::frame_id_t    frame_id
);

    import stream_pkg::*;

    sample_t    out_reg;
    frame_sum_t run_sum;
    logic       xfer;

    // ------------------------------------------------------------------------
    // FIFO pop into the output register
    // ------------------------------------------------------------------------
    assign xfer = out_valid && out_ready;
    assign rd   = !rd_empty && (!out_valid || out_ready);

    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            out_valid     <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= rd;
            if (rd) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd) begin
            out_reg <= rd_data;
        end
    end

    assign out_data  = out_reg.data;
    assign out_frame = out_reg.frame;
    assign out_last  = out_reg.last;

    // ------------------------------------------------------------------------
    // Per-frame sum
    // ------------------------------------------------------------------------
    // Sum including the sample on the output now
    assign frame_sum   = run_sum + frame_sum_t'(out_reg.data);
    assign frame_id    = out_reg.frame;
    assign frame_valid = xfer && out_reg.last;

    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            run_sum <= '0;
        end else if (xfer) begin
            run_sum <= out_reg.last ? '0 : frame_sum;
        end
    end

    a_rd_not_empty: assert property (@(posedge rd_clk) disable iff (local_rd_srst)
        rd |-> !rd_empty)
        else $error("sample_consumer: pop from empty FIFO");

endmodule : sample_consumer

/* verilog/stream_top.sv */
`timescale 1ns/1ps

module stream_top #(
    parameter int DEPTH = fifo_pkg::DEFAULT_DEPTH
) (
    input  logic                     rd_clk,
    input  logic                     local_rd_srst,
    input  logic                     in_valid,
    input  stream_pkg::sample_data_t in_data,
    input  logic                     in_last,
    output logic                     in_ready,
    output logic                     out_valid,
    input  logic                     out_ready,
    output stream_pkg::sample_data_t out_data,
    output stream_pkg::frame_id_t    out_frame,
    output logic                     out_last,
    output logic                     frame_valid,
    output stream_pkg::frame_sum_t   frame_sum,
    output stream_pkg::frame_id_t    frame_id
);

    import stream_pkg::*;

    logic    wr;
    sample_t wr_data;
    logic    credit_return;
    logic    rd;
    sample_t rd_data;
    logic    rd_empty;

    sample_producer #(
        .DEPTH ( DEPTH )
    ) sample_producer_inst (
        .rd_clk        ( rd_clk ),
        .local_rd_srst ( local_rd_srst ),
        .in_valid      ( in_valid ),
        .in_data       ( in_data ),
        .in_last       ( in_last ),
        .in_ready      ( in_ready ),
        .credit_return ( credit_return ),
        .wr            ( wr ),
        .wr_data       ( wr_data )
    );

    // Status outputs are left open, credits keep the FIFO in range
    fifo_core #(
        .DATA_T ( sample_t ),
        .DEPTH  ( DEPTH )
    ) fifo_core_inst (
        .rd_clk        ( rd_clk ),
        .local_rd_srst ( local_rd_srst ),
        .wr            ( wr ),
        .wr_data       ( wr_data ),
        .wr_full       ( ),
        .wr_oflow      ( ),
        .rd            ( rd ),
        .rd_data       ( rd_data ),
        .rd_empty      ( rd_empty ),
        .rd_count      ( ),
        .rd_uflow      ( )
    );

    sample_consumer sample_consumer_inst (
        .rd_clk        ( rd_clk ),
        .local_rd_srst ( local_rd_srst ),
        .rd_empty      ( rd_empty ),
        .rd_data       ( rd_data ),
        .rd            ( rd ),
        .credit_return ( credit_return ),
        .out_valid     ( out_valid ),
        .out_ready     ( out_ready ),
        .out_data      ( out_data ),
        .out_frame     ( out_frame ),
        .out_last      ( out_last ),
        .frame_valid   ( frame_valid ),
        .frame_sum     ( frame_sum ),
        .frame_id      ( frame_id )
    );

endmodule : stream_top

/* verif/stream_tb.sv */
`timescale 1ns/1ps

module stream_tb;

    import fifo_pkg::*;
    import stream_pkg::*;

    localparam int DEPTH      = DEFAULT_DEPTH;
    localparam int WAIT_LIMIT = 2000;

    logic         rd_clk = 1'b0;
    logic         local_rd_srst;
    logic         in_valid;
    sample_data_t in_data;
    logic         in_last;
    logic         in_ready;
    logic         out_valid;
    logic         out_ready;
    sample_data_t out_data;
    frame_id_t    out_frame;
    logic         out_last;
    logic         frame_valid;
    frame_sum_t   frame_sum;
    frame_id_t    frame_id;

    // Reference model
    sample_t      exp_q[$];
    frame_sum_t   exp_sum_q[$];
    frame_id_t    exp_fid_q[$];
    frame_id_t    exp_frame = '0;
    frame_sum_t   exp_sum = '0;

    int unsigned  cycle = 0;
    int unsigned  accept_cycle = 0;
    int unsigned  last_xfer_cycle = 0;
    int           ready_run = 0;
    logic         random_stall;

    stream_top #(
        .DEPTH ( DEPTH )
    ) stream_top_inst (
        .rd_clk        ( rd_clk ),
        .local_rd_srst ( local_rd_srst ),
        .in_valid      ( in_valid ),
        .in_data       ( in_data ),
        .in_last       ( in_last ),
        .in_ready      ( in_ready ),
        .out_valid     ( out_valid ),
        .out_ready     ( out_ready ),
        .out_data      ( out_data ),
        .out_frame     ( out_frame ),
        .out_last      ( out_last ),
        .frame_valid   ( frame_valid ),
        .frame_sum     ( frame_sum ),
        .frame_id      ( frame_id )
    );

    always #20 rd_clk = ~rd_clk;

    always @(posedge rd_clk) begin
        cycle <= cycle + 1;
    end

    // Random output stalls
    always @(posedge rd_clk) begin
        if (random_stall) begin
            out_ready <= (($urandom % 2) == 1);
        end
    end

    // ------------------------------------------------------------------------
    // Error reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at time %0t: %s got %b expected %b",
                $time, name, got, exp));
        end
    endtask

    task automatic compare_sample(input sample_t got, input sample_t exp);
        if (got.data !== exp.data) begin
            stop_on_error($sformatf("Fail at time %0t: out_data got %h expected %h",
                $time, got.data, exp.data));
        end
        if (got.frame !== exp.frame) begin
            stop_on_error($sformatf("Fail at time %0t: out_frame got %0d expected %0d",
                $time, got.frame, exp.frame));
        end
        if (got.last !== exp.last) begin
            stop_on_error($sformatf("Fail at time %0t: out_last got %b expected %b",
                $time, got.last, exp.last));
        end
    endtask

    task automatic compare_frame_sum(input frame_sum_t got, input frame_sum_t exp,
                                     input frame_id_t got_id, input frame_id_t exp_id);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at time %0t: frame_sum got %h expected %h",
                $time, got, exp));
        end
        if (got_id !== exp_id) begin
            stop_on_error($sformatf("Fail at time %0t: frame_id got %0d expected %0d",
                $time, got_id, exp_id));
        end
    endtask

    // ------------------------------------------------------------------------
    // Output monitor
    // ------------------------------------------------------------------------
    always @(posedge rd_clk) begin
        sample_t got;
        if (!local_rd_srst) begin
            if (out_ready) begin
                ready_run = ready_run + 1;
            end else begin
                ready_run = 0;
            end
            // Two edges for the returned credit to reach the counter
            if (!in_ready && ready_run > 2) begin
                stop_on_error($sformatf("in_ready low at time %0t with no output stall", $time));
            end
            if (out_valid && out_ready) begin
                got.data  = out_data;
                got.frame = out_frame;
                got.last  = out_last;
                if (exp_q.size() == 0) begin
                    stop_on_error("A sample came out that was never sent");
                end
                compare_sample(got, exp_q.pop_front());
                last_xfer_cycle = cycle;
            end
            if (frame_valid) begin
                if (exp_sum_q.size() == 0) begin
                    stop_on_error("frame_valid pulsed with no frame expected");
                end
                compare_frame_sum(frame_sum, exp_sum_q.pop_front(), frame_id,
                    exp_fid_q.pop_front());
            end
        end
    end

    // ------------------------------------------------------------------------
    // Driver
    // ------------------------------------------------------------------------
    function automatic void record_accept(input sample_data_t data, input logic last);
        sample_t e;
        e.data  = data;
        e.frame = exp_frame;
        e.last  = last;
        exp_q.push_back(e);
        exp_sum      = exp_sum + frame_sum_t'(data);
        accept_cycle = cycle;
        if (last) begin
            exp_sum_q.push_back(exp_sum);
            exp_fid_q.push_back(exp_frame);
            exp_sum   = '0;
            exp_frame = exp_frame + 1'b1;
        end
    endfunction

    // Called right after a rising edge
    task automatic send_sample(input sample_data_t data, input logic last);
        int waited;
        waited = 0;
        in_valid <= 1'b1;
        in_data  <= data;
        in_last  <= last;
        do begin
            @(posedge rd_clk);
            waited++;
            if (!in_ready && waited > WAIT_LIMIT) begin
                stop_on_error("Timeout: an input sample was never accepted");
            end
        end while (!in_ready);
        record_accept(data, last);
    endtask

    task automatic send_frames(input int total);
        int left;
        int len;
        left = total;
        while (left > 0) begin
            len = 1 + int'($urandom % 6);
            if (len > left) begin
                len = left;
            end
            for (int i = 0; i < len; i++) begin
                send_sample(sample_data_t'($urandom), i == len - 1);
            end
            left -= len;
        end
    endtask

    task automatic wait_drained(input string what);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || exp_sum_q.size() != 0) begin
            @(negedge rd_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_error($sformatf("Timeout: %0d samples never came out during %s",
                    exp_q.size(), what));
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset_state();
        @(posedge rd_clk);
        compare_bit("in_ready", in_ready, 1'b1);
        compare_bit("out_valid", out_valid, 1'b0);
        compare_bit("frame_valid", frame_valid, 1'b0);
    endtask

    task automatic test_single_sample();
        int latency;
        @(posedge rd_clk);
        send_sample(sample_data_t'($urandom), 1'b1);
        in_valid <= 1'b0;
        wait_drained("the single sample test");
        latency = int'(last_xfer_cycle - accept_cycle);
        if (latency != 4) begin
            stop_on_error($sformatf("Fail at time %0t: latency got %0d expected 4",
                $time, latency));
        end
    endtask

    task automatic test_streaming();
        @(posedge rd_clk);
        send_frames(40);
        in_valid <= 1'b0;
        wait_drained("the streaming test");
    endtask

    task automatic test_back_pressure();
        sample_data_t value;
        logic         last;
        int           accepted;
        int           waited;
        logic         full;
        accepted = 0;
        waited   = 0;
        full     = 1'b0;
        @(posedge rd_clk);
        out_ready <= 1'b0;
        value = sample_data_t'($urandom);
        last  = 1'b0;
        in_valid <= 1'b1;
        in_data  <= value;
        in_last  <= last;
        while (!full) begin
            @(posedge rd_clk);
            waited++;
            if (in_ready) begin
                record_accept(value, last);
                accepted++;
                value = sample_data_t'($urandom);
                last  = ((accepted % 4) == 3);
                in_data <= value;
                in_last <= last;
            end else begin
                full = 1'b1;
            end
            if (!full && waited > WAIT_LIMIT) begin
                stop_on_error("Timeout: in_ready never fell while the output was stalled");
            end
        end
        in_valid <= 1'b0;
        if (accepted != DEPTH + 1) begin
            stop_on_error($sformatf("Fail at time %0t: accepted count got %0d expected %0d",
                $time, accepted, DEPTH + 1));
        end
        @(posedge rd_clk);
        out_ready <= 1'b1;
        wait_drained("the back-pressure test");
    endtask

    task automatic test_random_stalls();
        @(posedge rd_clk);
        random_stall <= 1'b1;
        send_frames(60);
        in_valid     <= 1'b0;
        random_stall <= 1'b0;
        @(posedge rd_clk);
        out_ready <= 1'b1;
        wait_drained("the random stall test");
    endtask

    initial begin
        void'($urandom(18));
        local_rd_srst <= 1'b1;
        in_valid      <= 1'b0;
        in_data       <= '0;
        in_last       <= 1'b0;
        out_ready     <= 1'b1;
        random_stall  <= 1'b0;
        repeat (2) @(posedge rd_clk);
        local_rd_srst <= 1'b0;

        test_reset_state();
        test_single_sample();
        test_streaming();
        test_back_pressure();
        test_random_stalls();

        @(posedge rd_clk);
        if (exp_q.size() != 0 || exp_sum_q.size() != 0) begin
            stop_on_error("Samples or frame sums were left unchecked at the end of the run");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule : stream_tb

/* build.f */
verilog/fifo_pkg.sv
verilog/stream_pkg.sv
verilog/fifo_ram_sdp.sv
verilog/fifo_core.sv
verilog/sample_producer.sv
verilog/sample_consumer.sv
verilog/stream_top.sv
verif/stream_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the stream testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module stream_tb -o stream_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/stream_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0
